/* common/snn_pkg.sv */
`default_nettype none

package snn_pkg;

    ////////////////////////////////////////
    // Core sizes
    ////////////////////////////////////////
    localparam int num_groups   = 8;    // 4-bit spike groups per sample
    localparam int group_w      = 4;
    localparam int num_inputs   = 32;   // Inputs per layer
    localparam int weight_w     = 8;    // Signed weight
    localparam int weight_depth = 256;
    localparam int waddr_w      = 8;
    localparam int instr_depth  = 16;
    localparam int iaddr_w      = 4;
    localparam int pot_w        = 12;   // Potential and threshold
    localparam int result_w     = 13;   // Spike flag on top of the potential
    localparam int max_out      = 8;    // Output neurons per layer

    ////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////
    // Layer view, bit 15 set
    typedef struct packed {
        logic               op_layer;
        logic [2:0]         n_out_m1;   // Neuron count minus one
        logic [3:0]         rsvd;
        logic [waddr_w-1:0] w_base;     // First weight address
    } layer_instr_t;

    // Configuration view, bit 15 clear
    typedef struct packed {
        logic                    op_layer;
        logic [2:0]              rsvd;
        logic signed [pot_w-1:0] threshold;
    } cfg_instr_t;

    typedef union packed {
        layer_instr_t layer;
        cfg_instr_t   cfg;
    } instr_t;

endpackage

`default_nettype wire

/* design/spike_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_loader import snn_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [group_w-1:0]    i_spike_bin,
    input  logic                  i_valid_bin,
    input  logic                  i_start_inference,
    input  logic                  i_run_done,
    output logic [num_inputs-1:0] o_spikes,
    output logic                  o_start,
    output logic                  o_clr_start_inf
);

    logic [$clog2(num_groups)-1:0] grp_cnt;
    logic loaded;       // All eight groups written
    logic running;
    logic start_req;
    logic clr_d1;

    assign start_req = loaded && i_start_inference && !running;

    // Buffer is frozen once loaded, so the run sees a stable sample
    always_ff @(posedge clk) begin
        if (i_valid_bin && !loaded) begin
            o_spikes[grp_cnt*group_w +: group_w] <= i_spike_bin;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grp_cnt         <= '0;
            loaded          <= 1'b0;
            running         <= 1'b0;
            o_start         <= 1'b0;
            clr_d1          <= 1'b0;
            o_clr_start_inf <= 1'b0;
        end else begin
            o_start         <= start_req;
            clr_d1          <= o_start;     // Host clear lags start by two cycles
            o_clr_start_inf <= clr_d1;
            if (i_run_done) begin
                grp_cnt <= '0;              // Re-arm for the next sample
                loaded  <= 1'b0;
                running <= 1'b0;
            end else begin
                if (start_req) begin
                    running <= 1'b1;
                end
                if (i_valid_bin && !loaded) begin
                    grp_cnt <= grp_cnt + 1'b1;  // Wraps after the last group
                    if (grp_cnt == num_groups - 1) begin
                        loaded <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode import snn_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_imem_wr_en,
    input  logic [iaddr_w-1:0]      i_imem_addr,
    input  instr_t                  i_imem_dat,
    input  logic                    i_start,
    input  logic [iaddr_w:0]        i_num_instr,
    input  logic                    i_layer_done,
    output logic                    o_layer_go,
    output logic [waddr_w-1:0]      o_w_base,
    output logic [2:0]              o_n_out,
    output logic signed [pot_w-1:0] o_threshold,
    output logic                    o_end_inference
);

    instr_t imem [instr_depth];
    instr_t instr_q;

    logic [iaddr_w-1:0] pc;
    logic [iaddr_w:0]   done_cnt;   // Instructions finished in this run
    logic fetch;                    // Read of imem[pc] in progress
    logic exec;                     // instr_q holds the current word
    logic wait_layer;
    logic step;
    logic last;

    ////////////////////////////////////////
    // Program memory
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_imem_wr_en) begin
            imem[i_imem_addr] <= i_imem_dat;
        end
        instr_q <= imem[pc];
    end

    // Config retires in its exec cycle, a layer once execute reports done
    assign step = (exec && !instr_q.layer.op_layer) || (wait_layer && i_layer_done);
    assign last = (done_cnt + 1'b1) == i_num_instr;

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc              <= '0;
            done_cnt        <= '0;
            fetch           <= 1'b0;
            exec            <= 1'b0;
            wait_layer      <= 1'b0;
            o_layer_go      <= 1'b0;
            o_end_inference <= 1'b0;
            o_threshold     <= '0;
        end else begin
            o_layer_go      <= 1'b0;
            o_end_inference <= 1'b0;
            fetch           <= 1'b0;
            exec            <= fetch;
            if (i_start) begin
                pc       <= '0;
                done_cnt <= '0;
                if (i_num_instr == '0) begin
                    o_end_inference <= 1'b1;    // Empty program
                end else begin
                    fetch <= 1'b1;
                end
            end
            if (exec) begin
                if (instr_q.layer.op_layer) begin
                    o_layer_go <= 1'b1;
                    wait_layer <= 1'b1;
                end else begin
                    o_threshold <= instr_q.cfg.threshold;
                end
            end
            if (wait_layer && i_layer_done) begin
                wait_layer <= 1'b0;
            end
            if (step) begin
                done_cnt <= done_cnt + 1'b1;
                if (last) begin
                    o_end_inference <= 1'b1;
                end else begin
                    pc    <= pc + 1'b1;
                    fetch <= 1'b1;
                end
            end
        end
    end

    // Layer fields, valid together with o_layer_go
    always_ff @(posedge clk) begin
        if (exec && instr_q.layer.op_layer) begin
            o_w_base <= instr_q.layer.w_base;
            o_n_out  <= instr_q.layer.n_out_m1;
        end
    end

endmodule

`default_nettype wire

/* neuron_core/weight_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_mem import snn_pkg::*; (
    input  logic                clk,
    input  logic                i_wr_en,
    input  logic [waddr_w-1:0]  i_waddr,
    input  logic [weight_w-1:0] i_wdat,
    input  logic [waddr_w-1:0]  i_raddr,
    output logic [weight_w-1:0] o_rdata
);

    logic [weight_w-1:0] mem [weight_depth];

    // Single port behaviour, host write wins over the read
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_waddr] <= i_wdat;
        end else begin
            o_rdata <= mem[i_raddr];    // One cycle read latency
        end
    end

endmodule

`default_nettype wire

/* neuron_core/lif_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module lif_execute import snn_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_layer_go,
    input  logic [waddr_w-1:0]      i_w_base,
    input  logic [2:0]              i_n_out,
    input  logic signed [pot_w-1:0] i_threshold,
    input  logic [num_inputs-1:0]   i_spikes,
    input  logic                    i_res_busy,
    input  logic                    i_wmem_wr_en,
    input  logic [waddr_w-1:0]      i_wmem_addr,
    input  logic [weight_w-1:0]     i_wmem_dat,
    output logic                    o_layer_done,
    output logic                    o_res_valid,
    output logic [result_w-1:0]     o_res_data
);

    logic [$clog2(max_out)-1:0]    nrn;
    logic [$clog2(num_inputs)-1:0] inp;
    logic active;
    logic stall;
    logic issue;
    logic [waddr_w-1:0]         weight_raddr;
    logic signed [weight_w-1:0] weight_rdata;
    // Tags that travel with the read in flight
    logic rd_v;
    logic rd_first;
    logic rd_last;
    logic rd_lastn;
    logic rd_spk;
    logic signed [weight_w+$clog2(num_inputs):0] term;
    logic signed [weight_w+$clog2(num_inputs):0] acc;
    logic signed [weight_w+$clog2(num_inputs):0] sum;
    logic signed [pot_w-1:0] sat;
    logic res_pend;     // Finished neuron waiting for the result port
    logic res_last;

    assign stall        = res_pend && i_res_busy;
    assign issue        = active && !stall;
    assign weight_raddr = i_w_base + {nrn, inp};   // nrn*32 + inp, wraps at 256
    assign o_res_valid  = res_pend && !i_res_busy;

    weight_mem u_weight_mem (
        .clk     (clk),
        .i_wr_en (i_wmem_wr_en),
        .i_waddr (i_wmem_addr),
        .i_wdat  (i_wmem_dat),
        .i_raddr (weight_raddr),
        .o_rdata (weight_rdata)
    );

    ////////////////////////////////////////
    // Read issue
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            nrn    <= '0;
            inp    <= '0;
            rd_v   <= 1'b0;
        end else begin
            rd_v <= issue;
            if (i_layer_go) begin
                active <= 1'b1;
                nrn    <= '0;
                inp    <= '0;
            end else if (issue) begin
                inp <= inp + 1'b1;
                if (&inp) begin
                    nrn <= nrn + 1'b1;
                    if (nrn == i_n_out) begin
                        active <= 1'b0;     // Last read of the layer issued
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_first <= (inp == '0);
        rd_last  <= &inp;
        rd_lastn <= (nrn == i_n_out);
        rd_spk   <= i_spikes[inp];
    end

    ////////////////////////////////////////
    // Accumulate and fire
    ////////////////////////////////////////
    always_comb begin
        if (rd_spk) begin
            term = weight_rdata;            // Sign extended
        end else begin
            term = '0;
        end
        if (rd_first) begin
            sum = term;                     // Every neuron starts from zero
        end else begin
            sum = acc + term;
        end
        // Clamp to the 12-bit signed range
        if ((&sum[$bits(sum)-1:pot_w-1]) || !(|sum[$bits(sum)-1:pot_w-1])) begin
            sat = sum[pot_w-1:0];
        end else if (sum[$bits(sum)-1]) begin
            sat = {1'b1, {(pot_w-1){1'b0}}};
        end else begin
            sat = {1'b0, {(pot_w-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_v) begin
            acc <= sum;
        end
        if (rd_v && rd_last) begin
            o_res_data <= {sat >= i_threshold, sat};
            res_last   <= rd_lastn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_pend     <= 1'b0;
            o_layer_done <= 1'b0;
        end else begin
            o_layer_done <= o_res_valid && res_last;   // After the last hand-off
            if (rd_v && rd_last) begin
                res_pend <= 1'b1;
            end else if (o_res_valid) begin
                res_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/result_port.sv */
`timescale 1ns/1ps
`default_nettype none

module result_port import snn_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_res_valid,
    input  logic [result_w-1:0] i_res_data,
    input  logic                i_clr_valid_ll_ext,
    output logic                o_res_busy,
    output logic [result_w-1:0] o_data_last_layer,
    output logic                o_valid_last_layer
);

    logic accept;

    assign accept     = i_res_valid && !o_valid_last_layer;
    assign o_res_busy = o_valid_last_layer;    // One entry, full while valid

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid_last_layer <= 1'b0;
        end else if (accept) begin
            o_valid_last_layer <= 1'b1;
        end else if (i_clr_valid_ll_ext) begin
            o_valid_last_layer <= 1'b0;         // Drops the cycle after the clear
        end
    end

    // Data held stable until the host clears
    always_ff @(posedge clk) begin
        if (accept) begin
            o_data_last_layer <= i_res_data;
        end
    end

endmodule

`default_nettype wire

/* design/snn_top.sv */
`timescale 1ns/1ps
`default_nettype none

module snn_top import snn_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Spike input
    input  logic [group_w-1:0]  i_spike_bin,
    input  logic                i_valid_bin,
    // Host memory writes
    input  logic                i_wmem_wr_en,
    input  logic [waddr_w-1:0]  i_wmem_addr,
    input  logic [weight_w-1:0] i_wmem_dat,
    input  logic                i_imem_wr_en,
    input  logic [iaddr_w-1:0]  i_imem_addr,
    input  instr_t              i_imem_dat,
    // Run control
    input  logic                i_start_inference,
    input  logic [iaddr_w:0]    i_num_instr,
    output logic                o_clr_start_inf,
    output logic                o_end_inference,
    // Result exchange
    input  logic                i_clr_valid_ll_ext,
    output logic [result_w-1:0] o_data_last_layer,
    output logic                o_valid_last_layer
);

    logic [num_inputs-1:0]   spikes;
    logic                    start_pulse;
    logic                    layer_go;
    logic [waddr_w-1:0]      w_base;
    logic [2:0]              n_out;
    logic signed [pot_w-1:0] threshold;
    logic                    layer_done;
    logic                    res_valid;
    logic [result_w-1:0]     res_data;
    logic                    res_busy;

    spike_loader u_spike_loader (
        .clk               (clk),
        .rst               (rst),
        .i_spike_bin       (i_spike_bin),
        .i_valid_bin       (i_valid_bin),
        .i_start_inference (i_start_inference),
        .i_run_done        (o_end_inference),   // Frees the buffer for the next sample
        .o_spikes          (spikes),
        .o_start           (start_pulse),
        .o_clr_start_inf   (o_clr_start_inf)
    );

    instr_decode u_instr_decode (
        .clk             (clk),
        .rst             (rst),
        .i_imem_wr_en    (i_imem_wr_en),
        .i_imem_addr     (i_imem_addr),
        .i_imem_dat      (i_imem_dat),
        .i_start         (start_pulse),
        .i_num_instr     (i_num_instr),
        .i_layer_done    (layer_done),
        .o_layer_go      (layer_go),
        .o_w_base        (w_base),
        .o_n_out         (n_out),
        .o_threshold     (threshold),
        .o_end_inference (o_end_inference)
    );

    lif_execute u_lif_execute (
        .clk          (clk),
        .rst          (rst),
        .i_layer_go   (layer_go),
        .i_w_base     (w_base),
        .i_n_out      (n_out),
        .i_threshold  (threshold),
        .i_spikes     (spikes),
        .i_res_busy   (res_busy),
        .i_wmem_wr_en (i_wmem_wr_en),
        .i_wmem_addr  (i_wmem_addr),
        .i_wmem_dat   (i_wmem_dat),
        .o_layer_done (layer_done),
        .o_res_valid  (res_valid),
        .o_res_data   (res_data)
    );

    result_port u_result_port (
        .clk                (clk),
        .rst                (rst),
        .i_res_valid        (res_valid),
        .i_res_data         (res_data),
        .i_clr_valid_ll_ext (i_clr_valid_ll_ext),
        .o_res_busy         (res_busy),
        .o_data_last_layer  (o_data_last_layer),
        .o_valid_last_layer (o_valid_last_layer)
    );

endmodule

`default_nettype wire

/* test/snn_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module snn_clk_gen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;     // 20 ns period
    end

    // Reset held over three rising edges, released on a falling edge
    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

/* test/snn_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module snn_checker import snn_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                i_valid,
    input logic [result_w-1:0] i_data,
    input logic                i_clr,
    input logic                i_end,
    input logic                i_clr_start
);

    int fail_cnt = 0;   // Read by the testbench at the end of the run

    // Held result stays put until the host clears it
    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        i_valid && !i_clr |=> i_valid && $stable(i_data))
        else begin
            fail_cnt++;
            $error("result valid dropped or data changed without a clear");
        end

    a_valid_drop: assert property (@(posedge clk) disable iff (rst)
        i_valid && i_clr |=> !i_valid)
        else begin
            fail_cnt++;
            $error("result valid still high the cycle after a clear");
        end

    a_end_pulse: assert property (@(posedge clk) disable iff (rst)
        i_end |=> !i_end)
        else begin
            fail_cnt++;
            $error("end of inference wider than one cycle");
        end

    a_clr_pulse: assert property (@(posedge clk) disable iff (rst)
        i_clr_start |=> !i_clr_start)
        else begin
            fail_cnt++;
            $error("start clear wider than one cycle");
        end

endmodule

bind snn_top snn_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (o_valid_last_layer),
    .i_data      (o_data_last_layer),
    .i_clr       (i_clr_valid_ll_ext),
    .i_end       (o_end_inference),
    .i_clr_start (o_clr_start_inf)
);

`default_nettype wire

/* test/snn_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module snn_tb import snn_pkg::*; ();

    localparam int num_tests  = 7;
    localparam int wait_limit = 600;    // Cycles per wait loop
    localparam int w_random   = 0;
    localparam int w_max      = 1;
    localparam int w_min      = 2;

    logic                clk;
    logic                rst;
    logic [group_w-1:0]  i_spike_bin;
    logic                i_valid_bin;
    logic                i_wmem_wr_en;
    logic [waddr_w-1:0]  i_wmem_addr;
    logic [weight_w-1:0] i_wmem_dat;
    logic                i_imem_wr_en;
    logic [iaddr_w-1:0]  i_imem_addr;
    instr_t              i_imem_dat;
    logic                i_start_inference;
    logic [iaddr_w:0]    i_num_instr;
    logic                o_clr_start_inf;
    logic                o_end_inference;
    logic                i_clr_valid_ll_ext;
    logic [result_w-1:0] o_data_last_layer;
    logic                o_valid_last_layer;

    // One row per test
    string              t_name      [num_tests];
    logic [31:0]        t_spikes    [num_tests];
    logic               t_rand_spk  [num_tests];
    int                 t_thr       [num_tests];
    int                 t_thr_first [num_tests];
    logic               t_two_cfg   [num_tests];
    int                 t_n_out     [num_tests];
    logic [waddr_w-1:0] t_base      [num_tests];
    int                 t_wmode     [num_tests];

    logic [31:0]                lfsr_state;
    logic signed [weight_w-1:0] w_shadow [weight_depth];   // Host view of the weight memory
    logic [result_w-1:0]        exp_res  [max_out];
    string cur_name;
    int err_cnt     = 0;
    int check_cnt   = 0;
    int test_cnt    = 0;
    int end_cnt     = 0;
    int clr_cnt     = 0;
    int rise_cnt    = 0;
    int rise_at_end = 0;
    logic valid_prev = 1'b0;

    snn_clk_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    snn_top u_dut (.*);

    // Pulse and result counters sampled mid-cycle
    always @(negedge clk) begin
        valid_prev <= o_valid_last_layer;
        if (!rst) begin
            if (o_valid_last_layer && !valid_prev) begin
                rise_cnt <= rise_cnt + 1;
            end
            if (o_end_inference) begin
                end_cnt     <= end_cnt + 1;
                rise_at_end <= rise_cnt;    // Results seen when the run ended
            end
            if (o_clr_start_inf) begin
                clr_cnt <= clr_cnt + 1;
            end
        end
    end

    ////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [result_w-1:0] ref_result(input logic [31:0] spk,
            input logic [waddr_w-1:0] base, input int nrn, input int thr);
        int sum;
        int idx;
        logic signed [31:0] sat;
        sum = 0;
        for (int i = 0; i < num_inputs; i++) begin
            idx = (int'(base) + nrn * num_inputs + i) % weight_depth;
            if (spk[i]) begin
                sum += int'(w_shadow[idx]);
            end
        end
        if (sum > 2 ** (pot_w - 1) - 1) begin
            sat = 2 ** (pot_w - 1) - 1;
        end else if (sum < -(2 ** (pot_w - 1))) begin
            sat = -(2 ** (pot_w - 1));
        end else begin
            sat = sum;
        end
        return {sat >= thr, sat[pot_w-1:0]};
    endfunction

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////
    task automatic check_val(input string what, input logic [31:0] exp_v,
            input logic [31:0] act_v);
        check_cnt++;
        if (exp_v !== act_v) begin
            err_cnt++;
            $display("mismatch %s %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
        end
    endtask

    task automatic end_run();
        int total;
        total = err_cnt + u_dut.u_checker.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, total);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        err_cnt++;
        $display("%s in test %s", why, cur_name);
        end_run();
    endtask

    ////////////////////////////////////////
    // Wait loops
    ////////////////////////////////////////
    task automatic wait_reset();
        int n;
        n = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) begin
                abort_run("reset never released");
            end
        end
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!o_valid_last_layer) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) begin
                abort_run("no result arrived");
            end
        end
    endtask

    task automatic wait_end(input int target);
        int n;
        n = 0;
        while (end_cnt < target) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) begin
                abort_run("end of inference never pulsed");
            end
        end
    endtask

    ////////////////////////////////////////
    // Host actions
    ////////////////////////////////////////
    task automatic set_row(input int r, input string name, input logic [31:0] spk,
            input logic rnd, input int thr, input int thr_first, input logic two_cfg,
            input int n_out, input logic [waddr_w-1:0] base, input int wmode);
        t_name[r]      = name;
        t_spikes[r]    = spk;
        t_rand_spk[r]  = rnd;
        t_thr[r]       = thr;
        t_thr_first[r] = thr_first;
        t_two_cfg[r]   = two_cfg;
        t_n_out[r]     = n_out;
        t_base[r]      = base;
        t_wmode[r]     = wmode;
    endtask

    task automatic fill_table();
        set_row(0, "rand_a",   32'h0, 1'b1,    0,    0, 1'b0, 4, 8'h00, w_random);
        set_row(1, "rand_b",   32'h0, 1'b1,   60,    0, 1'b0, 8, 8'h40, w_random);
        set_row(2, "two_cfg",  32'hffff_0000, 1'b0, -2048, 2047, 1'b1, 3, 8'he0, w_random);
        set_row(3, "sat_pos",  32'hffff_ffff, 1'b0, 2047,  0, 1'b0, 2, 8'h10, w_max);
        set_row(4, "sat_neg",  32'hffff_ffff, 1'b0, -2047, 0, 1'b0, 2, 8'h80, w_min);
        set_row(5, "sparse",   32'h8000_0001, 1'b0,    1,  0, 1'b0, 1, 8'h33, w_random);
        set_row(6, "no_spike", 32'h0, 1'b0,    0,    0, 1'b0, 5, 8'h21, w_random);
    endtask

    task automatic write_weights(input int r);
        int idx;
        logic [31:0] v;
        for (int i = 0; i < t_n_out[r] * num_inputs; i++) begin
            idx = (int'(t_base[r]) + i) % weight_depth;
            case (t_wmode[r])
                w_max:   v = 32'h7f;
                w_min:   v = 32'h80;
                default: take_bits(weight_w, v);
            endcase
            w_shadow[idx] = v[weight_w-1:0];
            i_wmem_wr_en  = 1'b1;
            i_wmem_addr   = idx[waddr_w-1:0];
            i_wmem_dat    = v[weight_w-1:0];
            @(negedge clk);
        end
        i_wmem_wr_en = 1'b0;
    endtask

    task automatic write_instr(input int addr, input logic [15:0] word);
        i_imem_wr_en = 1'b1;
        i_imem_addr  = addr[iaddr_w-1:0];
        i_imem_dat   = word;
        @(negedge clk);
        i_imem_wr_en = 1'b0;
    endtask

    // Op in bit 15, count-1 in 14..12, base or threshold in the low bits
    task automatic write_program(input int r);
        logic [31:0] thr0;
        logic [31:0] thr1;
        logic [31:0] n_m1;
        int pc;
        thr0 = t_thr_first[r];
        thr1 = t_thr[r];
        n_m1 = t_n_out[r] - 1;
        pc   = 0;
        if (t_two_cfg[r]) begin
            write_instr(pc, {1'b0, 3'b000, thr0[11:0]});
            pc++;
        end
        write_instr(pc, {1'b0, 3'b000, thr1[11:0]});
        write_instr(pc + 1, {1'b1, n_m1[2:0], 4'b0000, t_base[r]});
        i_num_instr = pc + 2;
    endtask

    task automatic load_sample(input logic [31:0] spk);
        for (int g = 0; g < num_groups; g++) begin
            i_valid_bin = 1'b1;
            i_spike_bin = spk[g*group_w +: group_w];
            @(negedge clk);
        end
        i_valid_bin = 1'b0;
    endtask

    task automatic collect_results(input int n);
        logic [result_w-1:0] held;
        logic [31:0] d;
        for (int k = 0; k < n; k++) begin
            wait_valid();
            held = o_data_last_layer;
            check_val($sformatf("neuron %0d", k), exp_res[k], held);
            take_bits(3, d);    // Host clear delay of 0 to 7 cycles
            repeat (d[2:0]) begin
                @(negedge clk);
                check_val("valid held", 1, o_valid_last_layer);
                check_val("data held", held, o_data_last_layer);
            end
            i_clr_valid_ll_ext = 1'b1;
            @(negedge clk);
            i_clr_valid_ll_ext = 1'b0;
            check_val("valid after clear", 0, o_valid_last_layer);
        end
    endtask

    task automatic run_test(input int r);
        logic [31:0] spk;
        int errs_before;
        int end_before;
        int clr_before;
        int rise_before;
        cur_name    = t_name[r];
        errs_before = err_cnt;
        spk         = t_spikes[r];
        if (t_rand_spk[r]) begin
            take_bits(num_inputs, spk);
        end
        write_weights(r);
        write_program(r);
        load_sample(spk);
        for (int k = 0; k < t_n_out[r]; k++) begin
            exp_res[k] = ref_result(spk, t_base[r], k, t_thr[r]);
        end
        if (r == 0) begin
            check_val("start clears before start", 0, clr_cnt);
            check_val("end pulses before start", 0, end_cnt);
            check_val("results before start", 0, rise_cnt);
        end
        end_before  = end_cnt;
        clr_before  = clr_cnt;
        rise_before = rise_cnt;
        i_start_inference = 1'b1;
        @(negedge clk);
        i_start_inference = 1'b0;
        collect_results(t_n_out[r]);
        wait_end(end_before + 1);
        repeat (4) @(negedge clk);
        check_val("end pulses", 1, end_cnt - end_before);
        check_val("start clear pulses", 1, clr_cnt - clr_before);
        check_val("result count", t_n_out[r], rise_cnt - rise_before);
        check_val("results before end", rise_before + t_n_out[r], rise_at_end);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", cur_name);
        end else begin
            $display("test %s: %0d errors", cur_name, err_cnt - errs_before);
        end
    endtask

    initial begin
        lfsr_state         = 32'hedd0_31f5;
        i_spike_bin        = '0;
        i_valid_bin        = 1'b0;
        i_wmem_wr_en       = 1'b0;
        i_wmem_addr        = '0;
        i_wmem_dat         = '0;
        i_imem_wr_en       = 1'b0;
        i_imem_addr        = '0;
        i_imem_dat         = '0;
        i_start_inference  = 1'b0;
        i_num_instr        = '0;
        i_clr_valid_ll_ext = 1'b0;
        cur_name           = "reset";
        fill_table();
        wait_reset();
        // Outputs quiet while idle
        repeat (8) begin
            @(negedge clk);
            check_val("valid after reset", 0, o_valid_last_layer);
            check_val("end after reset", 0, o_end_inference);
            check_val("start clear after reset", 0, o_clr_start_inf);
        end
        for (int r = 0; r < num_tests; r++) begin
            run_test(r);
        end
        end_run();
    end

endmodule

`default_nettype wire

/* snn_top.f */
common/snn_pkg.sv
design/spike_loader.sv
design/instr_decode.sv
neuron_core/weight_mem.sv
neuron_core/lif_execute.sv
design/result_port.sv
design/snn_top.sv
test/snn_clk_gen.sv
test/snn_checker.sv
test/snn_tb.sv

/* Bender.yml */
package:
  name: snn_top

sources:
  - files:
      - common/snn_pkg.sv
      - design/spike_loader.sv
      - design/instr_decode.sv
      - neuron_core/weight_mem.sv
      - neuron_core/lif_execute.sv
      - design/result_port.sv
      - design/snn_top.sv
  - target: test
    files:
      - test/snn_clk_gen.sv
      - test/snn_checker.sv
      - test/snn_tb.sv
